/* hw/periph_pkg.sv */
/*
 * peripheral subsystem definitions
 * bus widths, MMIO page, register offsets and timer config bits
 */
package periph_pkg;

  // bus and pin widths
  localparam int BUS_W  = 32;
  localparam int STRB_W = BUS_W / 8;
  localparam int GPIO_W = 16;
  localparam int IRQ_W  = 4;

  // upper address bits of the peripheral page
  localparam logic [23:0] MMIO_PAGE = 24'h03_0000;

  // gpio register offsets
  localparam logic [7:0] GPIO_DATA = 8'h00;
  localparam logic [7:0] GPIO_OEB  = 8'h04;
  localparam logic [7:0] GPIO_PU   = 8'h08;
  localparam logic [7:0] GPIO_PD   = 8'h0C;
  localparam logic [7:0] IRQA_SRC  = 8'h18;
  localparam logic [7:0] IRQB_SRC  = 8'h1C;

  // timer register offsets
  localparam logic [7:0] TIM0_CFG = 8'h5C;
  localparam logic [7:0] TIM0_VAL = 8'h60;
  localparam logic [7:0] TIM0_DAT = 8'h64;
  localparam logic [7:0] TIM1_CFG = 8'h68;
  localparam logic [7:0] TIM1_VAL = 8'h6C;
  localparam logic [7:0] TIM1_DAT = 8'h70;

  // timer config fields
  localparam int CFG_W       = 3;
  localparam int CFG_EN      = 0;
  localparam int CFG_ONESHOT = 1;
  localparam int CFG_IRQ_EN  = 2;

endpackage

/* hw/counter_timer.sv */
/*
 * down-counting timer with reload value, one-shot mode and irq pulse
 */
module counter_timer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cfg_we_i,
  input  logic [periph_pkg::STRB_W-1:0] val_we_i,
  input  logic [periph_pkg::STRB_W-1:0] dat_we_i,
  input  logic [periph_pkg::BUS_W-1:0]  wdata_i,
  output logic [periph_pkg::CFG_W-1:0]  cfg_o,
  output logic [periph_pkg::BUS_W-1:0]  val_o,
  output logic [periph_pkg::BUS_W-1:0]  dat_o,
  output logic                          irq_o
);
  logic [periph_pkg::CFG_W-1:0] r_cfg;
  logic [periph_pkg::BUS_W-1:0] r_val;
  logic [periph_pkg::BUS_W-1:0] r_dat;
  logic                         r_irq;
  logic                         s_count;
  logic                         s_expire;

  function automatic logic [periph_pkg::BUS_W-1:0] byte_wr(
    input logic [periph_pkg::BUS_W-1:0]  old_v,
    input logic [periph_pkg::BUS_W-1:0]  wd,
    input logic [periph_pkg::STRB_W-1:0] we
  );
    logic [periph_pkg::BUS_W-1:0] v;
    v = old_v;
    for (int b = 0; b < periph_pkg::STRB_W; b++) begin
      if (we[b]) v[b*8 +: 8] = wd[b*8 +: 8];
    end
    return v;
  endfunction

  // a bus write to cfg or count holds off counting for that cycle
  assign s_count  = r_cfg[periph_pkg::CFG_EN] && !cfg_we_i && (dat_we_i == '0);
  assign s_expire = s_count && (r_dat == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_cfg <= '0;
      r_val <= '0;
      r_dat <= '0;
      r_irq <= 1'b0;
    end else begin
      r_val <= byte_wr(r_val, wdata_i, val_we_i);
      r_irq <= s_expire && r_cfg[periph_pkg::CFG_IRQ_EN];

      if (cfg_we_i) begin
        r_cfg <= wdata_i[periph_pkg::CFG_W-1:0];
      end else if (s_expire && r_cfg[periph_pkg::CFG_ONESHOT]) begin
        // one-shot stops itself
        r_cfg[periph_pkg::CFG_EN] <= 1'b0;
      end

      if (dat_we_i != '0) begin
        r_dat <= byte_wr(r_dat, wdata_i, dat_we_i);
      end else if (s_count) begin
        if (r_dat != '0) begin
          r_dat <= r_dat - 1'b1;
        end else if (!r_cfg[periph_pkg::CFG_ONESHOT]) begin
          r_dat <= r_val;
        end
      end
    end
  end

  assign cfg_o = r_cfg;
  assign val_o = r_val;
  assign dat_o = r_dat;
  assign irq_o = r_irq;

endmodule

/* hw/gpio_regs.sv */
/*
 * gpio control registers and the two gpio-routed interrupt lines
 */
module gpio_regs (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [periph_pkg::GPIO_W/8-1:0] data_we_i,
  input  logic [periph_pkg::GPIO_W/8-1:0] oeb_we_i,
  input  logic [periph_pkg::GPIO_W/8-1:0] pu_we_i,
  input  logic [periph_pkg::GPIO_W/8-1:0] pd_we_i,
  input  logic                            irqa_src_we_i,
  input  logic                            irqb_src_we_i,
  input  logic [periph_pkg::BUS_W-1:0]    wdata_i,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_in_i,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_out_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_outenb_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_pullupb_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_pulldownb_o,
  output logic [2*periph_pkg::GPIO_W-1:0] data_o,
  output logic [periph_pkg::GPIO_W-1:0]   oeb_o,
  output logic [periph_pkg::GPIO_W-1:0]   pu_o,
  output logic [periph_pkg::GPIO_W-1:0]   pd_o,
  output logic [1:0]                      irqa_src_o,
  output logic [1:0]                      irqb_src_o,
  output logic                            irqa_o,
  output logic                            irqb_o
);
  logic [periph_pkg::GPIO_W-1:0] r_out;
  logic [periph_pkg::GPIO_W-1:0] r_oeb;
  logic [periph_pkg::GPIO_W-1:0] r_pu;
  logic [periph_pkg::GPIO_W-1:0] r_pd;
  logic [1:0]                    r_irqa_src;
  logic [1:0]                    r_irqb_src;

  // merge the strobed bytes of wd into old_v
  function automatic logic [periph_pkg::GPIO_W-1:0] byte_wr(
    input logic [periph_pkg::GPIO_W-1:0]   old_v,
    input logic [periph_pkg::BUS_W-1:0]    wd,
    input logic [periph_pkg::GPIO_W/8-1:0] we
  );
    logic [periph_pkg::GPIO_W-1:0] v;
    v = old_v;
    for (int b = 0; b < periph_pkg::GPIO_W / 8; b++) begin
      if (we[b]) v[b*8 +: 8] = wd[b*8 +: 8];
    end
    return v;
  endfunction

  // select 0 masks the line, 1..3 pick one of three pins
  function automatic logic irq_pick(input logic [1:0] src, input logic [2:0] pins);
    case (src)
      2'd1:    return pins[0];
      2'd2:    return pins[1];
      2'd3:    return pins[2];
      default: return 1'b0;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_out      <= '0;
      r_oeb      <= '1;
      r_pu       <= '0;
      r_pd       <= '0;
      r_irqa_src <= 2'd0;
      r_irqb_src <= 2'd0;
    end else begin
      r_out <= byte_wr(r_out, wdata_i, data_we_i);
      r_oeb <= byte_wr(r_oeb, wdata_i, oeb_we_i);
      r_pu  <= byte_wr(r_pu, wdata_i, pu_we_i);
      r_pd  <= byte_wr(r_pd, wdata_i, pd_we_i);
      if (irqa_src_we_i) r_irqa_src <= wdata_i[1:0];
      if (irqb_src_we_i) r_irqb_src <= wdata_i[1:0];
    end
  end

  // reset value of r_oeb tristates the pads
  assign gpio_outenb_o    = r_oeb;
  assign gpio_out_o       = r_out;
  assign gpio_pullupb_o   = r_pu;
  assign gpio_pulldownb_o = r_pd;

  assign data_o     = {r_out, gpio_in_i};
  assign oeb_o      = r_oeb;
  assign pu_o       = r_pu;
  assign pd_o       = r_pd;
  assign irqa_src_o = r_irqa_src;
  assign irqb_src_o = r_irqb_src;

  assign irqa_o = irq_pick(r_irqa_src, gpio_in_i[2:0]);
  assign irqb_o = irq_pick(r_irqb_src, gpio_in_i[5:3]);

endmodule

/* hw/bus_ctrl.sv */
/*
 * bus controller: decodes native bus requests into sram, mmio registers
 * or unmapped space, and answers every access with ready one cycle later
 */
module bus_ctrl #(
  parameter int MEM_WORDS = 1024,
  localparam int RAM_AW = $clog2(MEM_WORDS)
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            mem_valid_i,
  input  logic [periph_pkg::BUS_W-1:0]    mem_addr_i,
  input  logic [periph_pkg::BUS_W-1:0]    mem_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0]   mem_wstrb_i,
  output logic                            mem_ready_o,
  output logic [periph_pkg::BUS_W-1:0]    mem_rdata_o,
  output logic [periph_pkg::STRB_W-1:0]   ram_wstrb_o,
  output logic [RAM_AW-1:0]               ram_addr_o,
  output logic [periph_pkg::BUS_W-1:0]    ram_wdata_o,
  input  logic [periph_pkg::BUS_W-1:0]    ram_rdata_i,
  // gpio register strobes
  output logic [periph_pkg::GPIO_W/8-1:0] gpio_data_we_o,
  output logic [periph_pkg::GPIO_W/8-1:0] gpio_oeb_we_o,
  output logic [periph_pkg::GPIO_W/8-1:0] gpio_pu_we_o,
  output logic [periph_pkg::GPIO_W/8-1:0] gpio_pd_we_o,
  output logic                            irqa_src_we_o,
  output logic                            irqb_src_we_o,
  output logic [periph_pkg::BUS_W-1:0]    wdata_o,
  // gpio readback, data is {out, in}
  input  logic [2*periph_pkg::GPIO_W-1:0] gpio_data_i,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_oeb_i,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_pu_i,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_pd_i,
  input  logic [1:0]                      irqa_src_i,
  input  logic [1:0]                      irqb_src_i,
  // timers
  output logic                            tim0_cfg_we_o,
  output logic [periph_pkg::STRB_W-1:0]   tim0_val_we_o,
  output logic [periph_pkg::STRB_W-1:0]   tim0_dat_we_o,
  input  logic [periph_pkg::CFG_W-1:0]    tim0_cfg_i,
  input  logic [periph_pkg::BUS_W-1:0]    tim0_val_i,
  input  logic [periph_pkg::BUS_W-1:0]    tim0_dat_i,
  output logic                            tim1_cfg_we_o,
  output logic [periph_pkg::STRB_W-1:0]   tim1_val_we_o,
  output logic [periph_pkg::STRB_W-1:0]   tim1_dat_we_o,
  input  logic [periph_pkg::CFG_W-1:0]    tim1_cfg_i,
  input  logic [periph_pkg::BUS_W-1:0]    tim1_val_i,
  input  logic [periph_pkg::BUS_W-1:0]    tim1_dat_i
);
  localparam int GPAD = periph_pkg::BUS_W - periph_pkg::GPIO_W;
  localparam int CPAD = periph_pkg::BUS_W - periph_pkg::CFG_W;

  logic                         r_ready;
  logic                         r_ram_sel;
  logic [periph_pkg::BUS_W-1:0] r_rdata;
  logic [periph_pkg::BUS_W-1:0] s_mmio_rdata;
  logic                         s_pending;
  logic                         s_ram_range;
  logic                         s_mmio;
  logic [7:0]                   s_off;

  // a request is decoded once, in the cycle before ready
  assign s_pending   = mem_valid_i && !r_ready;
  assign s_ram_range = s_pending &&
                       (mem_addr_i < periph_pkg::BUS_W'(4 * MEM_WORDS));
  assign s_mmio      = s_pending && (mem_addr_i[periph_pkg::BUS_W-1:8] == periph_pkg::MMIO_PAGE);
  assign s_off       = mem_addr_i[7:0];

  // sram side
  assign ram_wstrb_o = s_ram_range ? mem_wstrb_i : '0;
  assign ram_addr_o  = mem_addr_i[RAM_AW+1:2];
  assign ram_wdata_o = mem_wdata_i;
  assign wdata_o     = mem_wdata_i;

  // per-register byte strobes
  always_comb begin
    gpio_data_we_o = '0;
    gpio_oeb_we_o  = '0;
    gpio_pu_we_o   = '0;
    gpio_pd_we_o   = '0;
    irqa_src_we_o  = 1'b0;
    irqb_src_we_o  = 1'b0;
    tim0_cfg_we_o  = 1'b0;
    tim0_val_we_o  = '0;
    tim0_dat_we_o  = '0;
    tim1_cfg_we_o  = 1'b0;
    tim1_val_we_o  = '0;
    tim1_dat_we_o  = '0;
    if (s_mmio) begin
      case (s_off)
        periph_pkg::GPIO_DATA: gpio_data_we_o = mem_wstrb_i[periph_pkg::GPIO_W/8-1:0];
        periph_pkg::GPIO_OEB:  gpio_oeb_we_o  = mem_wstrb_i[periph_pkg::GPIO_W/8-1:0];
        periph_pkg::GPIO_PU:   gpio_pu_we_o   = mem_wstrb_i[periph_pkg::GPIO_W/8-1:0];
        periph_pkg::GPIO_PD:   gpio_pd_we_o   = mem_wstrb_i[periph_pkg::GPIO_W/8-1:0];
        periph_pkg::IRQA_SRC:  irqa_src_we_o  = mem_wstrb_i[0];
        periph_pkg::IRQB_SRC:  irqb_src_we_o  = mem_wstrb_i[0];
        periph_pkg::TIM0_CFG:  tim0_cfg_we_o  = mem_wstrb_i[0];
        periph_pkg::TIM0_VAL:  tim0_val_we_o  = mem_wstrb_i;
        periph_pkg::TIM0_DAT:  tim0_dat_we_o  = mem_wstrb_i;
        periph_pkg::TIM1_CFG:  tim1_cfg_we_o  = mem_wstrb_i[0];
        periph_pkg::TIM1_VAL:  tim1_val_we_o  = mem_wstrb_i;
        periph_pkg::TIM1_DAT:  tim1_dat_we_o  = mem_wstrb_i;
        default: ;
      endcase
    end
  end

  // readback mux, zero for unassigned offsets and outside the page
  always_comb begin
    s_mmio_rdata = '0;
    if (s_mmio) begin
      case (s_off)
        periph_pkg::GPIO_DATA: s_mmio_rdata = gpio_data_i;
        periph_pkg::GPIO_OEB:  s_mmio_rdata = {{GPAD{1'b0}}, gpio_oeb_i};
        periph_pkg::GPIO_PU:   s_mmio_rdata = {{GPAD{1'b0}}, gpio_pu_i};
        periph_pkg::GPIO_PD:   s_mmio_rdata = {{GPAD{1'b0}}, gpio_pd_i};
        periph_pkg::IRQA_SRC:  s_mmio_rdata = {30'd0, irqa_src_i};
        periph_pkg::IRQB_SRC:  s_mmio_rdata = {30'd0, irqb_src_i};
        periph_pkg::TIM0_CFG:  s_mmio_rdata = {{CPAD{1'b0}}, tim0_cfg_i};
        periph_pkg::TIM0_VAL:  s_mmio_rdata = tim0_val_i;
        periph_pkg::TIM0_DAT:  s_mmio_rdata = tim0_dat_i;
        periph_pkg::TIM1_CFG:  s_mmio_rdata = {{CPAD{1'b0}}, tim1_cfg_i};
        periph_pkg::TIM1_VAL:  s_mmio_rdata = tim1_val_i;
        periph_pkg::TIM1_DAT:  s_mmio_rdata = tim1_dat_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_ready   <= 1'b0;
      r_ram_sel <= 1'b0;
    end else begin
      // fixed one cycle latency for every target
      r_ready   <= s_pending;
      r_ram_sel <= s_ram_range;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s_pending) begin
      r_rdata <= s_mmio_rdata;
    end
  end

  assign mem_ready_o = r_ready;
  // sram data arrives directly in the ready cycle
  assign mem_rdata_o = r_ram_sel ? ram_rdata_i : r_rdata;

endmodule

/* hw/periph_subsys.sv */
/*
 * peripheral subsystem top level
 * bus decode, sixteen gpios and two timers behind the native memory bus
 */
module periph_subsys #(
  parameter int MEM_WORDS = 1024,
  localparam int RAM_AW = $clog2(MEM_WORDS)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // native memory bus
  input  logic                          mem_valid_i,
  input  logic [periph_pkg::BUS_W-1:0]  mem_addr_i,
  input  logic [periph_pkg::BUS_W-1:0]  mem_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0] mem_wstrb_i,
  output logic                          mem_ready_o,
  output logic [periph_pkg::BUS_W-1:0]  mem_rdata_o,
  // sram port
  output logic [periph_pkg::STRB_W-1:0] ram_wstrb_o,
  output logic [RAM_AW-1:0]             ram_addr_o,
  output logic [periph_pkg::BUS_W-1:0]  ram_wdata_o,
  input  logic [periph_pkg::BUS_W-1:0]  ram_rdata_i,
  // gpio pads
  input  logic [periph_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [periph_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_outenb_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_pullupb_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_pulldownb_o,
  // tim0, tim1, gpio irq a, gpio irq b
  output logic [periph_pkg::IRQ_W-1:0]  irq_o
);
  logic [periph_pkg::GPIO_W/8-1:0]   s_gpio_data_we;
  logic [periph_pkg::GPIO_W/8-1:0]   s_gpio_oeb_we;
  logic [periph_pkg::GPIO_W/8-1:0]   s_gpio_pu_we;
  logic [periph_pkg::GPIO_W/8-1:0]   s_gpio_pd_we;
  logic                              s_irqa_src_we;
  logic                              s_irqb_src_we;
  logic [periph_pkg::BUS_W-1:0]      s_wdata;
  logic [2*periph_pkg::GPIO_W-1:0]   s_gpio_data;
  logic [periph_pkg::GPIO_W-1:0]     s_gpio_oeb;
  logic [periph_pkg::GPIO_W-1:0]     s_gpio_pu;
  logic [periph_pkg::GPIO_W-1:0]     s_gpio_pd;
  logic [1:0]                        s_irqa_src;
  logic [1:0]                        s_irqb_src;
  logic                              s_tim0_cfg_we;
  logic [periph_pkg::STRB_W-1:0]     s_tim0_val_we;
  logic [periph_pkg::STRB_W-1:0]     s_tim0_dat_we;
  logic [periph_pkg::CFG_W-1:0]      s_tim0_cfg;
  logic [periph_pkg::BUS_W-1:0]      s_tim0_val;
  logic [periph_pkg::BUS_W-1:0]      s_tim0_dat;
  logic                              s_tim1_cfg_we;
  logic [periph_pkg::STRB_W-1:0]     s_tim1_val_we;
  logic [periph_pkg::STRB_W-1:0]     s_tim1_dat_we;
  logic [periph_pkg::CFG_W-1:0]      s_tim1_cfg;
  logic [periph_pkg::BUS_W-1:0]      s_tim1_val;
  logic [periph_pkg::BUS_W-1:0]      s_tim1_dat;

  bus_ctrl #(
    .MEM_WORDS(MEM_WORDS)
  ) u_bus_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_valid_i  (mem_valid_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_wstrb_i  (mem_wstrb_i),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o),
    .ram_wstrb_o  (ram_wstrb_o),
    .ram_addr_o   (ram_addr_o),
    .ram_wdata_o  (ram_wdata_o),
    .ram_rdata_i  (ram_rdata_i),
    .gpio_data_we_o(s_gpio_data_we),
    .gpio_oeb_we_o(s_gpio_oeb_we),
    .gpio_pu_we_o (s_gpio_pu_we),
    .gpio_pd_we_o (s_gpio_pd_we),
    .irqa_src_we_o(s_irqa_src_we),
    .irqb_src_we_o(s_irqb_src_we),
    .wdata_o      (s_wdata),
    .gpio_data_i  (s_gpio_data),
    .gpio_oeb_i   (s_gpio_oeb),
    .gpio_pu_i    (s_gpio_pu),
    .gpio_pd_i    (s_gpio_pd),
    .irqa_src_i   (s_irqa_src),
    .irqb_src_i   (s_irqb_src),
    .tim0_cfg_we_o(s_tim0_cfg_we),
    .tim0_val_we_o(s_tim0_val_we),
    .tim0_dat_we_o(s_tim0_dat_we),
    .tim0_cfg_i   (s_tim0_cfg),
    .tim0_val_i   (s_tim0_val),
    .tim0_dat_i   (s_tim0_dat),
    .tim1_cfg_we_o(s_tim1_cfg_we),
    .tim1_val_we_o(s_tim1_val_we),
    .tim1_dat_we_o(s_tim1_dat_we),
    .tim1_cfg_i   (s_tim1_cfg),
    .tim1_val_i   (s_tim1_val),
    .tim1_dat_i   (s_tim1_dat)
  );

  gpio_regs u_gpio_regs (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .data_we_i       (s_gpio_data_we),
    .oeb_we_i        (s_gpio_oeb_we),
    .pu_we_i         (s_gpio_pu_we),
    .pd_we_i         (s_gpio_pd_we),
    .irqa_src_we_i   (s_irqa_src_we),
    .irqb_src_we_i   (s_irqb_src_we),
    .wdata_i         (s_wdata),
    .gpio_in_i       (gpio_in_i),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .data_o          (s_gpio_data),
    .oeb_o           (s_gpio_oeb),
    .pu_o            (s_gpio_pu),
    .pd_o            (s_gpio_pd),
    .irqa_src_o      (s_irqa_src),
    .irqb_src_o      (s_irqb_src),
    .irqa_o          (irq_o[2]),
    .irqb_o          (irq_o[3])
  );

  counter_timer u_tim0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cfg_we_i(s_tim0_cfg_we),
    .val_we_i(s_tim0_val_we),
    .dat_we_i(s_tim0_dat_we),
    .wdata_i (s_wdata),
    .cfg_o   (s_tim0_cfg),
    .val_o   (s_tim0_val),
    .dat_o   (s_tim0_dat),
    .irq_o   (irq_o[0])
  );

  counter_timer u_tim1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cfg_we_i(s_tim1_cfg_we),
    .val_we_i(s_tim1_val_we),
    .dat_we_i(s_tim1_dat_we),
    .wdata_i (s_wdata),
    .cfg_o   (s_tim1_cfg),
    .val_o   (s_tim1_val),
    .dat_o   (s_tim1_dat),
    .irq_o   (irq_o[1])
  );

endmodule

/* sim/tb_bus_tasks.svh */
/*
 * bus access and irq wait tasks of the peripheral subsystem testbench
 */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// waits for ready, takes the read data and ends the request
task automatic complete_access(input logic [31:0] addr, output logic got_ready,
                               output logic [31:0] rdata);
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (!mem_ready_o && waited < READY_WAIT) begin
    @(negedge clk_i);
    waited++;
  end
  got_ready = mem_ready_o;
  rdata = mem_rdata_o;
  if (!got_ready) begin
    ready_errs++;
    $display("no ready for the access to 0x%08h within %0d cycles", addr, READY_WAIT);
  end else if (waited != 1) begin
    // ready belongs one cycle after the edge that first sees valid
    ready_errs++;
    $display("CHECK FAILED @%0t: ready for 0x%08h after %0d cycles, expected 1",
             $time, addr, waited);
  end
  @(posedge clk_i);
  mem_valid_i <= 1'b0;
  mem_wstrb_i <= '0;
endtask

task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
  logic        ok;
  logic [31:0] unused;
  @(posedge clk_i);
  mem_valid_i <= 1'b1;
  mem_addr_i  <= addr;
  mem_wdata_i <= data;
  mem_wstrb_i <= strb;
  complete_access(addr, ok, unused);
endtask

// zero strobes make the request a read
task automatic read_word(input logic [31:0] addr, input logic [31:0] exp,
                         input logic [31:0] mask);
  logic        ok;
  logic [31:0] got;
  @(posedge clk_i);
  mem_valid_i <= 1'b1;
  mem_addr_i  <= addr;
  mem_wdata_i <= '0;
  mem_wstrb_i <= '0;
  complete_access(addr, ok, got);
  if (ok && ((got & mask) !== (exp & mask))) begin
    value_errs++;
    $display("CHECK FAILED @%0t: read 0x%08h returned 0x%08h, expected 0x%08h",
             $time, addr, got, exp);
  end
endtask

task automatic wait_irq(input int bit_idx, input int cycles);
  int   n;
  logic seen;
  n = 0;
  seen = 1'b0;
  while (!seen && n < cycles) begin
    @(negedge clk_i);
    n++;
    seen = irq_o[bit_idx];
  end
  if (!seen) begin
    irq_errs++;
    $display("irq bit %0d did not fire within %0d cycles at %0t", bit_idx, cycles, $time);
  end
endtask

`endif

/* sim/tb_periph_subsys.sv */
/*
 * testbench for the peripheral subsystem
 * runs the case file against the DUT and a one-cycle-latency sram model
 */
module tb_periph_subsys;
  localparam int MEM_WORDS  = 1024;
  localparam int RAM_AW     = $clog2(MEM_WORDS);
  localparam int CASE_COLS  = 4;
  localparam int MAX_CASES  = 96;
  localparam int READY_WAIT = 8;

  logic                          clk_i = 1'b0;
  logic                          rst_n_i;
  logic                          mem_valid_i;
  logic [periph_pkg::BUS_W-1:0]  mem_addr_i;
  logic [periph_pkg::BUS_W-1:0]  mem_wdata_i;
  logic [periph_pkg::STRB_W-1:0] mem_wstrb_i;
  logic                          mem_ready_o;
  logic [periph_pkg::BUS_W-1:0]  mem_rdata_o;
  logic [periph_pkg::STRB_W-1:0] ram_wstrb_o;
  logic [RAM_AW-1:0]             ram_addr_o;
  logic [periph_pkg::BUS_W-1:0]  ram_wdata_o;
  logic [periph_pkg::BUS_W-1:0]  ram_rdata_i = '0;
  logic [periph_pkg::GPIO_W-1:0] gpio_in_i;
  logic [periph_pkg::GPIO_W-1:0] gpio_out_o;
  logic [periph_pkg::GPIO_W-1:0] gpio_outenb_o;
  logic [periph_pkg::GPIO_W-1:0] gpio_pullupb_o;
  logic [periph_pkg::GPIO_W-1:0] gpio_pulldownb_o;
  logic [periph_pkg::IRQ_W-1:0]  irq_o;

  logic [31:0] ram [0:MEM_WORDS-1];
  logic [31:0] cases [0:CASE_COLS*MAX_CASES-1];
  int value_errs = 0;
  int ready_errs = 0;
  int irq_errs = 0;
  int case_errs = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  always #10 clk_i = ~clk_i;

  periph_subsys #(
    .MEM_WORDS(MEM_WORDS)
  ) dut0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_valid_i     (mem_valid_i),
    .mem_addr_i      (mem_addr_i),
    .mem_wdata_i     (mem_wdata_i),
    .mem_wstrb_i     (mem_wstrb_i),
    .mem_ready_o     (mem_ready_o),
    .mem_rdata_o     (mem_rdata_o),
    .ram_wstrb_o     (ram_wstrb_o),
    .ram_addr_o      (ram_addr_o),
    .ram_wdata_o     (ram_wdata_o),
    .ram_rdata_i     (ram_rdata_i),
    .gpio_in_i       (gpio_in_i),
    .gpio_out_o      (gpio_out_o),
    .gpio_outenb_o   (gpio_outenb_o),
    .gpio_pullupb_o  (gpio_pullupb_o),
    .gpio_pulldownb_o(gpio_pulldownb_o),
    .irq_o           (irq_o)
  );

  `include "tb_bus_tasks.svh"

  // sram model returns data one cycle after the address
  always @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb_o[b]) ram[ram_addr_o][b*8 +: 8] <= ram_wdata_o[b*8 +: 8];
    end
    ram_rdata_i <= ram[ram_addr_o];
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: case list not finished after %0d cycles", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_quiet(input string when);
    if (mem_ready_o !== 1'b0 || irq_o !== '0 || ram_wstrb_o !== '0) begin
      value_errs++;
      $display("CHECK FAILED @%0t: bus, sram or irq output active %s", $time, when);
    end
    if (gpio_outenb_o !== 16'hffff) begin
      value_errs++;
      $display("CHECK FAILED @%0t: gpio_outenb_o is 0x%04h %s", $time, gpio_outenb_o, when);
    end
  endtask

  // sel 0 out, 1 output-enable-bar, 2 pull-up, 3 pull-down
  task automatic check_pins(input logic [1:0] sel, input logic [15:0] exp);
    logic [15:0] got;
    @(negedge clk_i);
    case (sel)
      2'd0:    got = gpio_out_o;
      2'd1:    got = gpio_outenb_o;
      2'd2:    got = gpio_pullupb_o;
      default: got = gpio_pulldownb_o;
    endcase
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED @%0t: pin group %0d is 0x%04h, expected 0x%04h",
               $time, sel, got, exp);
    end
  endtask

  task automatic watch_irq_low(input int bit_idx, input int cycles);
    logic fired;
    fired = 1'b0;
    for (int n = 0; n < cycles && !fired; n++) begin
      @(negedge clk_i);
      fired = irq_o[bit_idx];
    end
    if (fired) begin
      irq_errs++;
      $display("CHECK FAILED @%0t: irq bit %0d high, expected low", $time, bit_idx);
    end
  endtask

  function automatic int case_cycles(input logic [31:0] op, input logic [31:0] arg);
    if (op >= 32'h1 && op <= 32'h4) return 4;
    if (op == 32'h6 || op == 32'h7) return int'(arg);
    return 1;
  endfunction

  task automatic run_case(input int idx);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] arg;
    op   = cases[idx*CASE_COLS];
    addr = cases[idx*CASE_COLS+1];
    data = cases[idx*CASE_COLS+2];
    arg  = cases[idx*CASE_COLS+3];
    case (op)
      32'h1: write_word({periph_pkg::MMIO_PAGE, addr[7:0]}, data, arg[3:0]);
      32'h2: read_word({periph_pkg::MMIO_PAGE, addr[7:0]}, data, arg);
      32'h3: write_word(addr, data, arg[3:0]);
      32'h4: read_word(addr, data, arg);
      32'h5: begin
        @(posedge clk_i);
        gpio_in_i <= data[15:0];
      end
      32'h6: wait_irq(int'(addr), int'(arg));
      32'h7: watch_irq_low(int'(addr), int'(arg));
      32'h8: check_pins(addr[1:0], data[15:0]);
      default: begin
        case_errs++;
        $display("case %0d has an unknown operation 0x%0h", idx, op);
      end
    endcase
  endtask

  initial begin
    int n_cases;
    int budget;
    int total;
    void'($urandom(42));
    rst_n_i     = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    gpio_in_i   = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram[i] <= $urandom();
    end
    $readmemh("sim/periph_cases.txt", cases);
    n_cases = 0;
    budget = 0;
    while (n_cases < MAX_CASES && cases[n_cases*CASE_COLS] != 32'hf) begin
      budget += case_cycles(cases[n_cases*CASE_COLS], cases[n_cases*CASE_COLS+3]);
      n_cases++;
    end
    if (n_cases == MAX_CASES) begin
      case_errs++;
      $display("case file has no end marker within %0d cases", MAX_CASES);
    end
    cycle_limit = 10 * (budget + 8) + 100;

    // 8 cycles of reset, checked halfway
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_quiet("during reset");
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_quiet("after reset");

    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end

    total = value_errs + ready_errs + irq_errs + case_errs;
    $display("errors: %0d value, %0d ready, %0d irq, %0d case file",
             value_errs, ready_errs, irq_errs, case_errs);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* sim/periph_cases.txt */
// columns: op addr data arg, all hex; op 1/2 mmio wr/rd, 3/4 raw wr/rd, 5 gpio in, 6 irq within,
// 7 irq low, 8 pins, f end; wr arg strobes; rd data expect, arg mask; irq addr bit, arg cycles
// gpio reset values and byte writes
2 00 00000000 ffffffff
2 04 0000ffff ffffffff
2 08 00000000 ffffffff
2 0c 00000000 ffffffff
1 00 0000a5c3 1
8 0 000000c3 0
1 04 00001234 2
8 1 000012ff 0
1 08 0000beef 3
8 2 0000beef 0
1 0c 00005a00 2
8 3 00005a00 0
2 04 000012ff ffffffff
2 08 0000beef ffffffff
2 0c 00005a00 ffffffff
5 0 00003c96 0
2 00 00c33c96 ffffffff
// irq a follows inputs 0..2, irq b inputs 3..5
5 0 00000000 0
1 18 00000001 1
5 0 00000006 0
7 2 0 3
5 0 00000001 0
6 2 0 2
1 18 00000002 1
5 0 00000002 0
6 2 0 2
1 18 00000003 1
5 0 00000004 0
6 2 0 2
1 18 00000000 1
5 0 0000003f 0
7 2 0 3
7 3 0 3
1 1c 00000001 1
6 3 0 2
1 1c 00000002 1
5 0 00000010 0
6 3 0 2
1 1c 00000003 1
5 0 00000018 0
7 3 0 3
5 0 00000020 0
6 3 0 2
2 1c 00000003 ffffffff
5 0 00000000 0
// timer 0 one-shot from 20, irq within 25 cycles
1 60 00000014 f
1 64 00000014 f
1 5c 00000007 1
6 0 0 19
2 5c 00000006 ffffffff
2 64 00000000 ffffffff
2 60 00000014 ffffffff
// timer 1 continuous, timer 0 idle, then timer 0 without irq enable
1 6c 00000008 f
1 70 00000008 f
1 68 00000005 1
6 1 0 14
6 1 0 14
7 0 0 1e
1 68 00000000 1
1 64 0000000a f
1 5c 00000003 1
7 0 0 28
2 5c 00000002 ffffffff
2 64 00000000 ffffffff
// sram, unmapped space and unassigned page offsets
3 00000000 cafef00d f
3 00000010 11223344 f
3 00000010 aabbccdd 6
4 00000010 11bbcc44 ffffffff
3 00000ffc 0badc0de f
4 00000ffc 0badc0de ffffffff
3 00100000 deadbeef f
4 00000000 cafef00d ffffffff
4 00100000 00000000 ffffffff
2 14 00000000 ffffffff
2 40 00000000 ffffffff
f 0 0 0

/* list.f */
+incdir+sim
hw/periph_pkg.sv
hw/counter_timer.sv
hw/gpio_regs.sv
hw/bus_ctrl.sv
hw/periph_subsys.sv
sim/tb_periph_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_periph_subsys -f list.f

out=$(./obj_dir/Vtb_periph_subsys)
echo "$out"
echo "$out" | grep -qx "PASS: all tests"
